//--- ssm_config.svh
// ssm config: widths, lane count, group size and pipeline latencies of the tile engine
`ifndef SSM_CONFIG_SVH
`define SSM_CONFIG_SVH

// ==================================================
// numeric format, signed Q8.8
// ==================================================
`define SSM_DW              16
`define SSM_FRAC            8
`define SSM_ACC_W           32

// ==================================================
// tile geometry
// ==================================================
`define SSM_N_TILE          4
`define SSM_TILES_PER_GROUP 4

// stage counts of the two pipelines
`define SSM_LAT_UPD         3
`define SSM_LAT_RD          2

`endif

//--- ssm_data_pkg.sv
// ssm data types: Q8.8 samples, lane vectors, tile input bundle and fixed-point multiply
`include "ssm_config.svh"

package ssm_data_pkg;

    // one signed Q8.8 sample
    typedef logic signed [`SSM_DW-1:0] sample_t;

    // all lanes of one tile, lane 0 in the low bits
    typedef logic [`SSM_N_TILE*`SSM_DW-1:0] lane_vec_t;

    // wide signed sum for readout and group totals
    typedef logic signed [`SSM_ACC_W-1:0] acc_t;

    // everything one tile brings in
    typedef struct packed {
        sample_t   dt;
        sample_t   dA;
        sample_t   x;
        sample_t   D;
        lane_vec_t B;
        lane_vec_t C;
        lane_vec_t hprev;
    } tile_in_t;

    // skip path operands, carried down to the group accumulator
    typedef struct packed {
        sample_t x;
        sample_t D;
    } skip_t;

    // full signed product, rescaled by the fraction bits, low word kept
    function automatic sample_t q_mul(input sample_t a, input sample_t b);
        logic signed [2*`SSM_DW-1:0] prod;
        prod = a * b;
        return sample_t'(prod >>> `SSM_FRAC);
    endfunction

endpackage

//--- ssm_ctrl_pkg.sv
// ssm control types: per-tile group tags and group accumulator states
package ssm_ctrl_pkg;

    // position of a tile inside its group
    typedef struct packed {
        logic first;
        logic last;
    } tile_tag_t;

    // group accumulator FSM
    // idle waits for a first tile, accum collects until the last one
    typedef enum logic [0:0] {
        GRP_IDLE  = 1'b0,
        GRP_ACCUM = 1'b1
    } grp_state_e;

endpackage

//--- ssm_tile_counter.sv
// ssm tile counter: counts accepted tiles per group and tags the first and last tile
`timescale 1ns/10ps
`include "ssm_config.svh"

module ssm_tile_counter
    import ssm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      tile_valid_i,
    output tile_tag_t tag_o
);

    // wide enough to hold the group size itself
    localparam int               CNT_W    = $clog2(`SSM_TILES_PER_GROUP + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SSM_TILES_PER_GROUP - 1);

    logic [CNT_W-1:0] cnt_q;

    // tiles seen so far in the open group
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_q <= '0;
        end else if (tile_valid_i) begin
            // wrap on the last tile of the group
            if (cnt_q == CNT_LAST) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + CNT_W'(1);
            end
        end
    end

    // tags describe the tile presented this cycle
    assign tag_o.first = (cnt_q == '0);
    assign tag_o.last  = (cnt_q == CNT_LAST);

    // count stays inside one group
    a_cnt_in_group: assert property (
        @(posedge clk) disable iff (!rstn)
        cnt_q < CNT_W'(`SSM_TILES_PER_GROUP)
    );

endmodule

//--- ssm_group_fsm.sv
// ssm group FSM: turns readout tags into load, add and emit strobes for the accumulator
`timescale 1ns/10ps

module ssm_group_fsm
    import ssm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      valid_i,
    input  tile_tag_t tag_i,
    output logic      load_o,
    output logic      add_o,
    output logic      emit_o
);

    grp_state_e state_q;
    grp_state_e state_d;

    // ==================================================
    // next state and strobes
    // ==================================================
    always_comb begin
        load_o  = 1'b0;
        add_o   = 1'b0;
        emit_o  = 1'b0;
        state_d = state_q;
        case (state_q)
            GRP_IDLE: begin
                // group opens on its first tile
                if (valid_i && tag_i.first) begin
                    load_o  = 1'b1;
                    state_d = GRP_ACCUM;
                    // single-tile group closes at once
                    if (tag_i.last) begin
                        emit_o  = 1'b1;
                        state_d = GRP_IDLE;
                    end
                end
            end
            GRP_ACCUM: begin
                if (valid_i) begin
                    add_o = 1'b1;
                    if (tag_i.last) begin
                        emit_o  = 1'b1;
                        state_d = GRP_IDLE;
                    end
                end
            end
            default: state_d = GRP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= GRP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // counter tags and pipeline order keep groups from overlapping
    a_no_first_in_accum: assert property (
        @(posedge clk) disable iff (!rstn)
        (state_q == GRP_ACCUM && valid_i) |-> !tag_i.first
    );

endmodule

//--- ssm_state_update.sv
// ssm state update: three-stage pipeline computing hnext = dA*hprev + (dt*x)*B per lane
`timescale 1ns/10ps
`include "ssm_config.svh"

module ssm_state_update
    import ssm_data_pkg::*;
    import ssm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      valid_i,
    input  tile_in_t  tile_i,
    input  tile_tag_t tag_i,
    output logic      valid_o,
    output lane_vec_t hnext_o,
    output lane_vec_t c_o,
    output skip_t     skip_o,
    output tile_tag_t tag_o
);

    // fields that ride along untouched
    typedef struct packed {
        lane_vec_t c;
        skip_t     skip;
        tile_tag_t tag;
    } side_t;

    sample_t   dx_s1;
    lane_vec_t dah_s1;
    lane_vec_t b_s1;
    lane_vec_t dah_s2;
    lane_vec_t dbx_s2;
    lane_vec_t hnext_s3;

    side_t                  side_in;
    side_t                  side_q [`SSM_LAT_UPD];
    logic [`SSM_LAT_UPD-1:0] vld_q;

    // ==================================================
    // datapath
    // ==================================================
    // stage 1: dx and dA*hprev, B held for stage 2
    always_ff @(posedge clk) begin
        dx_s1 <= q_mul(tile_i.dt, tile_i.x);
        b_s1  <= tile_i.B;
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            dah_s1[i*`SSM_DW +: `SSM_DW] <= q_mul(tile_i.dA, tile_i.hprev[i*`SSM_DW +: `SSM_DW]);
        end
    end

    // stage 2: dx*B per lane
    always_ff @(posedge clk) begin
        dah_s2 <= dah_s1;
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            dbx_s2[i*`SSM_DW +: `SSM_DW] <= q_mul(dx_s1, b_s1[i*`SSM_DW +: `SSM_DW]);
        end
    end

    // stage 3: lane sums, wrap at sample width
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            hnext_s3[i*`SSM_DW +: `SSM_DW] <= dah_s2[i*`SSM_DW +: `SSM_DW]
                                            + dbx_s2[i*`SSM_DW +: `SSM_DW];
        end
    end

    // ==================================================
    // sideband and valid
    // ==================================================
    assign side_in.c      = tile_i.C;
    assign side_in.skip.x = tile_i.x;
    assign side_in.skip.D = tile_i.D;
    assign side_in.tag    = tag_i;

    // one slot per datapath stage
    always_ff @(posedge clk) begin
        side_q[0] <= side_in;
        for (int i = 1; i < `SSM_LAT_UPD; i++) begin
            side_q[i] <= side_q[i-1];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`SSM_LAT_UPD-2:0], valid_i};
        end
    end

    assign valid_o = vld_q[`SSM_LAT_UPD-1];
    assign hnext_o = hnext_s3;
    assign c_o     = side_q[`SSM_LAT_UPD-1].c;
    assign skip_o  = side_q[`SSM_LAT_UPD-1].skip;
    assign tag_o   = side_q[`SSM_LAT_UPD-1].tag;

endmodule

//--- ssm_readout.sv
// ssm readout: two-stage pipeline reducing hnext*C over the lanes into one tile sum
`timescale 1ns/10ps
`include "ssm_config.svh"

module ssm_readout
    import ssm_data_pkg::*;
    import ssm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      valid_i,
    input  lane_vec_t hnext_i,
    input  lane_vec_t c_i,
    input  skip_t     skip_i,
    input  tile_tag_t tag_i,
    output logic      valid_o,
    output acc_t      sum_o,
    output skip_t     skip_o,
    output tile_tag_t tag_o
);

    // skip operands and tag still needed at the accumulator
    typedef struct packed {
        skip_t     skip;
        tile_tag_t tag;
    } rd_side_t;

    lane_vec_t hc_s1;
    acc_t      lane_sum;
    acc_t      sum_s2;

    rd_side_t               side_in;
    rd_side_t               side_q [`SSM_LAT_RD];
    logic [`SSM_LAT_RD-1:0] vld_q;

    // stage 1: hnext*C per lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            hc_s1[i*`SSM_DW +: `SSM_DW] <= q_mul(hnext_i[i*`SSM_DW +: `SSM_DW],
                                                 c_i[i*`SSM_DW +: `SSM_DW]);
        end
    end

    // lane reduction, each product sign-extended first
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            lane_sum = lane_sum + acc_t'($signed(hc_s1[i*`SSM_DW +: `SSM_DW]));
        end
    end

    // stage 2: registered tile sum
    always_ff @(posedge clk) begin
        sum_s2 <= lane_sum;
    end

    // ==================================================
    // sideband and valid
    // ==================================================
    assign side_in.skip = skip_i;
    assign side_in.tag  = tag_i;

    always_ff @(posedge clk) begin
        side_q[0] <= side_in;
        for (int i = 1; i < `SSM_LAT_RD; i++) begin
            side_q[i] <= side_q[i-1];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`SSM_LAT_RD-2:0], valid_i};
        end
    end

    assign valid_o = vld_q[`SSM_LAT_RD-1];
    assign sum_o   = sum_s2;
    assign skip_o  = side_q[`SSM_LAT_RD-1].skip;
    assign tag_o   = side_q[`SSM_LAT_RD-1].tag;

endmodule

//--- ssm_group_accum.sv
// ssm group accumulator: sums tile results over a group, adds xD and registers y
`timescale 1ns/10ps

module ssm_group_accum
    import ssm_data_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  load_i,
    input  logic  add_i,
    input  logic  emit_i,
    input  acc_t  sum_i,
    input  skip_t skip_i,
    output acc_t  y_o,
    output logic  y_valid_o
);

    acc_t run_q;
    acc_t run_d;
    acc_t xd_q;
    acc_t xd_new;
    acc_t xd_cur;
    acc_t y_q;
    logic y_valid_q;

    // skip term of the group's first tile
    assign xd_new = acc_t'(q_mul(skip_i.x, skip_i.D));
    assign xd_cur = load_i ? xd_new : xd_q;

    // running sum including this cycle's tile
    always_comb begin
        run_d = run_q;
        if (load_i) begin
            run_d = sum_i;
        end else if (add_i) begin
            run_d = run_q + sum_i;
        end
    end

    // ==================================================
    // sum, skip latch and result register
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_q     <= '0;
            xd_q      <= '0;
            y_q       <= '0;
            y_valid_q <= 1'b0;
        end else begin
            run_q     <= run_d;
            y_valid_q <= emit_i;
            if (load_i) begin
                xd_q <= xd_new;
            end
            if (emit_i) begin
                y_q <= run_d + xd_cur;
            end
        end
    end

    assign y_o       = y_q;
    assign y_valid_o = y_valid_q;

    // emit always comes with the tile that closes the group
    a_emit_has_tile: assert property (
        @(posedge clk) disable iff (!rstn)
        emit_i |-> (load_i || add_i)
    );

endmodule

//--- ssm_block_top.sv
// ssm block top: tile counter, state update, readout, group FSM and accumulator wired up
`timescale 1ns/10ps

module ssm_block_top
    import ssm_data_pkg::*;
    import ssm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      tile_valid_i,
    input  tile_in_t  tile_i,
    output lane_vec_t hnext_o,
    output logic      hnext_valid_o,
    output acc_t      y_o,
    output logic      y_valid_o
);

    // tag of the tile at the input
    tile_tag_t in_tag;

    // state update outputs
    lane_vec_t upd_c;
    skip_t     upd_skip;
    tile_tag_t upd_tag;

    // readout outputs
    logic      rd_valid;
    acc_t      rd_sum;
    skip_t     rd_skip;
    tile_tag_t rd_tag;

    // accumulator strobes
    logic grp_load;
    logic grp_add;
    logic grp_emit;

    ssm_tile_counter u_tile_counter (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .tag_o        (in_tag)
    );

    ssm_state_update u_state_update (
        .clk     (clk),
        .rstn    (rstn),
        .valid_i (tile_valid_i),
        .tile_i  (tile_i),
        .tag_i   (in_tag),
        .valid_o (hnext_valid_o),
        .hnext_o (hnext_o),
        .c_o     (upd_c),
        .skip_o  (upd_skip),
        .tag_o   (upd_tag)
    );

    ssm_readout u_readout (
        .clk     (clk),
        .rstn    (rstn),
        .valid_i (hnext_valid_o),
        .hnext_i (hnext_o),
        .c_i     (upd_c),
        .skip_i  (upd_skip),
        .tag_i   (upd_tag),
        .valid_o (rd_valid),
        .sum_o   (rd_sum),
        .skip_o  (rd_skip),
        .tag_o   (rd_tag)
    );

    ssm_group_fsm u_group_fsm (
        .clk     (clk),
        .rstn    (rstn),
        .valid_i (rd_valid),
        .tag_i   (rd_tag),
        .load_o  (grp_load),
        .add_o   (grp_add),
        .emit_o  (grp_emit)
    );

    ssm_group_accum u_group_accum (
        .clk       (clk),
        .rstn      (rstn),
        .load_i    (grp_load),
        .add_i     (grp_add),
        .emit_i    (grp_emit),
        .sum_i     (rd_sum),
        .skip_i    (rd_skip),
        .y_o       (y_o),
        .y_valid_o (y_valid_o)
    );

endmodule

//--- ssm_checker.sv
// ssm checker: reference model of the tile engine, compares hnext and y with the DUT outputs
`timescale 1ns/10ps
`include "ssm_config.svh"

module ssm_checker
    import ssm_data_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      tile_valid_i,
    input  tile_in_t  tile_i,
    input  lane_vec_t hnext_i,
    input  logic      hnext_valid_i,
    input  acc_t      y_i,
    input  logic      y_valid_i,
    output int        hnext_errs_o,
    output int        y_errs_o,
    output int        proto_errs_o,
    output int        pending_o
);

    localparam int DW = `SSM_DW;

    int unsigned cyc;
    int          grp_pos;
    acc_t        grp_sum;
    acc_t        grp_xd;
    lane_vec_t   exp_h;
    acc_t        exp_s;

    // expectations, due cycle and value side by side
    int unsigned hn_due_q[$];
    lane_vec_t   hn_val_q[$];
    int unsigned y_due_q[$];
    acc_t        y_val_q[$];

    // Q8.8 product, bits 23..8 of the full product
    function automatic sample_t fx_mul(input sample_t a, input sample_t b);
        logic signed [31:0] p;
        p = a * b;
        return p[23:8];
    endfunction

    // next state per lane, 16-bit wrap on the add
    function automatic lane_vec_t model_hnext(input tile_in_t t);
        lane_vec_t h;
        sample_t   dx;
        dx = fx_mul(t.dt, t.x);
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            h[i*DW +: DW] = fx_mul(t.dA, t.hprev[i*DW +: DW]) + fx_mul(dx, t.B[i*DW +: DW]);
        end
        return h;
    endfunction

    // C-weighted lane sum, products sign-extended to 32 bits
    function automatic acc_t model_tile_sum(input lane_vec_t h, input lane_vec_t c);
        acc_t    s;
        sample_t p;
        s = '0;
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            p = fx_mul(h[i*DW +: DW], c[i*DW +: DW]);
            s = s + acc_t'(p);
        end
        return s;
    endfunction

    // ==================================================
    // per-cycle compare, then model update
    // ==================================================
    always @(posedge clk) begin
        if (!rstn) begin
            cyc     = 0;
            grp_pos = 0;
            grp_sum = '0;
            grp_xd  = '0;
            hn_due_q.delete();
            hn_val_q.delete();
            y_due_q.delete();
            y_val_q.delete();
        end else begin
            cyc = cyc + 1;
            // expectations whose cycle has passed
            while (hn_due_q.size() > 0 && hn_due_q[0] < cyc) begin
                $display("at %0t: hnext_valid_o missing, it was due on cycle %0d",
                         $time, hn_due_q[0]);
                proto_errs_o++;
                void'(hn_due_q.pop_front());
                void'(hn_val_q.pop_front());
            end
            while (y_due_q.size() > 0 && y_due_q[0] < cyc) begin
                $display("at %0t: y_valid_o missing, it was due on cycle %0d",
                         $time, y_due_q[0]);
                proto_errs_o++;
                void'(y_due_q.pop_front());
                void'(y_val_q.pop_front());
            end
            if (hnext_valid_i) begin
                if (hn_due_q.size() > 0 && hn_due_q[0] == cyc) begin
                    exp_h = hn_val_q.pop_front();
                    void'(hn_due_q.pop_front());
                    if (hnext_i !== exp_h) begin
                        $display("error at %0t: hnext_o = %h, expected %h",
                                 $time, hnext_i, exp_h);
                        hnext_errs_o++;
                    end
                end else begin
                    $display("at %0t: hnext_valid_o is high but no tile is due now", $time);
                    proto_errs_o++;
                end
            end
            if (y_valid_i) begin
                if (y_due_q.size() > 0 && y_due_q[0] == cyc) begin
                    exp_s = y_val_q.pop_front();
                    void'(y_due_q.pop_front());
                    if (y_i !== exp_s) begin
                        $display("error at %0t: y_o = %h, expected %h", $time, y_i, exp_s);
                        y_errs_o++;
                    end
                end else begin
                    $display("at %0t: y_valid_o is high but no group result is due now", $time);
                    proto_errs_o++;
                end
            end
            // accepted tile: state now, group result at the group's end
            if (tile_valid_i) begin
                exp_h = model_hnext(tile_i);
                exp_s = model_tile_sum(exp_h, tile_i.C);
                hn_due_q.push_back(cyc + `SSM_LAT_UPD);
                hn_val_q.push_back(exp_h);
                if (grp_pos == 0) begin
                    grp_sum = exp_s;
                    grp_xd  = acc_t'(fx_mul(tile_i.x, tile_i.D));
                end else begin
                    grp_sum = grp_sum + exp_s;
                end
                if (grp_pos == `SSM_TILES_PER_GROUP - 1) begin
                    y_due_q.push_back(cyc + `SSM_LAT_UPD + `SSM_LAT_RD + 1);
                    y_val_q.push_back(grp_sum + grp_xd);
                    grp_pos = 0;
                end else begin
                    grp_pos = grp_pos + 1;
                end
            end
        end
        pending_o = hn_due_q.size() + y_due_q.size();
    end

endmodule

//--- tb_ssm_block.sv
// ssm testbench: clock, reset, seeded random tiles for the tile engine and the final verdict
`timescale 1ns/10ps
`include "ssm_config.svh"

module tb_ssm_block
    import ssm_data_pkg::*;
();

    localparam int DW            = `SSM_DW;
    localparam int N_GROUPS      = 40;
    localparam int N_TILES       = N_GROUPS * `SSM_TILES_PER_GROUP;
    localparam int EXTREME_EVERY = 7;
    localparam int STIM_LIMIT    = N_TILES * 20;
    localparam int DRAIN_LIMIT   = 200;
    localparam int QUIET_CYCLES  = 12;

    logic      clk;
    logic      rstn;
    logic      tile_valid;
    tile_in_t  tile;
    lane_vec_t hnext;
    logic      hnext_valid;
    acc_t      y;
    logic      y_valid;
    int        hnext_errs;
    int        y_errs;
    int        proto_errs;
    int        pending;

    ssm_block_top ssm_block_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .tile_valid_i  (tile_valid),
        .tile_i        (tile),
        .hnext_o       (hnext),
        .hnext_valid_o (hnext_valid),
        .y_o           (y),
        .y_valid_o     (y_valid)
    );

    ssm_checker u_checker (
        .clk           (clk),
        .rstn          (rstn),
        .tile_valid_i  (tile_valid),
        .tile_i        (tile),
        .hnext_i       (hnext),
        .hnext_valid_i (hnext_valid),
        .y_i           (y),
        .y_valid_i     (y_valid),
        .hnext_errs_o  (hnext_errs),
        .y_errs_o      (y_errs),
        .proto_errs_o  (proto_errs),
        .pending_o     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // extreme mode picks from the corners of Q8.8
    function automatic sample_t rand_sample(input logic extreme);
        logic [31:0] r;
        r = $urandom;
        if (!extreme) begin
            return r[15:0];
        end
        case (r[1:0])
            2'd0:    return 16'h8000;
            2'd1:    return 16'h7fff;
            2'd2:    return 16'hffff;
            default: return 16'h0100;
        endcase
    endfunction

    function automatic tile_in_t rand_tile(input logic extreme);
        tile_in_t t;
        t.dt = rand_sample(extreme);
        t.dA = rand_sample(extreme);
        t.x  = rand_sample(extreme);
        t.D  = rand_sample(extreme);
        for (int i = 0; i < `SSM_N_TILE; i++) begin
            t.B[i*DW +: DW]     = rand_sample(extreme);
            t.C[i*DW +: DW]     = rand_sample(extreme);
            t.hprev[i*DW +: DW] = rand_sample(extreme);
        end
        return t;
    endfunction

    // ==================================================
    // stimulus and drain
    // ==================================================
    // about 60% of cycles carry a tile, idle cycles get junk data
    task automatic drive_tiles(output logic done);
        int sent;
        int cycles;
        sent   = 0;
        cycles = 0;
        while (sent < N_TILES && cycles < STIM_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if ($urandom_range(99, 0) < 60) begin
                tile       = rand_tile((sent % EXTREME_EVERY) == 0);
                tile_valid = 1'b1;
                sent++;
            end else begin
                tile       = rand_tile(1'b0);
                tile_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        tile_valid = 1'b0;
        done = (sent == N_TILES);
    endtask

    task automatic wait_drain(output logic drained);
        int guard;
        guard = 0;
        while (pending != 0 && guard < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            guard++;
        end
        drained = (pending == 0);
    endtask

    initial begin
        logic stim_done;
        logic drained;
        int   total;
        void'($urandom(94600));
        rstn       = 1'b0;
        tile_valid = 1'b0;
        tile       = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        // idle stretch, valids must stay low here
        repeat (5) @(posedge clk);
        drive_tiles(stim_done);
        if (!stim_done) begin
            $display("stimulus stopped after %0d cycles before all tiles were sent", STIM_LIMIT);
        end
        wait_drain(drained);
        if (!drained) begin
            $display("timeout: %0d outputs still expected after %0d cycles", pending, DRAIN_LIMIT);
        end else begin
            // watch for stray valids once the pipeline is empty
            repeat (QUIET_CYCLES) @(posedge clk);
            #1;
        end
        total = hnext_errs + y_errs + proto_errs;
        $display("hnext errors %0d, y errors %0d, protocol errors %0d",
                 hnext_errs, y_errs, proto_errs);
        if (total == 0 && drained && stim_done) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
ssm_data_pkg.sv
ssm_ctrl_pkg.sv
ssm_tile_counter.sv
ssm_group_fsm.sv
ssm_state_update.sv
ssm_readout.sv
ssm_group_accum.sv
ssm_block_top.sv
ssm_checker.sv
tb_ssm_block.sv

//--- run.sh
#!/bin/sh
# build and run the ssm testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_ssm_block -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ssm_block)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
